//--- design/core_pkg.sv
package core_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data and address width
  localparam int XLEN       = 32;
  // Register index width
  localparam int REG_ADDR_W = 5;
  // x0 included
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       addr_t;
  typedef logic [XLEN-1:0]       data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  // Bits 6:0 of the instruction word
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ADDI x0, x0, 0
  localparam data_t NOP_INSTR = 32'h0000_0013;

  //////////////////////////////
  // ALU operations
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SRL    = 4'd5,
    ALU_SRA    = 4'd6,
    ALU_OR     = 4'd7,
    ALU_AND    = 4'd8,
    // LUI, operand b straight through
    ALU_PASS_B = 4'd9
  } alu_op_e;

endpackage

//--- design/id_ex_if.sv
`timescale 1ns/1ps

// Decoded instruction, decode to execute
interface id_ex_if import core_pkg::*; ();

  logic      valid;
  alu_op_e   alu_op;
  data_t     operand_a;
  data_t     operand_b;
  reg_addr_t rd;
  logic      rd_we;
  logic      is_store;
  data_t     store_data;
  // Low only while a store waits for its grant
  logic      ready;

  // Decode side
  modport decode (
    output valid, alu_op, operand_a, operand_b, rd, rd_we, is_store, store_data,
    input  ready
  );

  // Execute side
  modport execute (
    input  valid, alu_op, operand_a, operand_b, rd, rd_we, is_store, store_data,
    output ready
  );

endinterface

//--- design/if_stage.sv
`timescale 1ns/1ps

module if_stage import core_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  fetch_enable_i,
  input  addr_t boot_addr_i,

  // Instruction bus
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_rvalid_i,
  input  data_t instr_rdata_i,

  // To decode
  output logic  instr_valid_o,
  output data_t instr_o,
  input  logic  id_ready_i
);

  // Address of the next request
  addr_t pc_q;

  // One-entry fetch buffer
  logic  buf_valid_q;
  logic  buf_valid_d;
  data_t buf_data_q;

  //////////////////////////////
  // Hand-off to decode
  //////////////////////////////

  // Buffered word is older, goes first
  assign instr_valid_o = buf_valid_q | instr_rvalid_i;
  assign instr_o       = buf_valid_q ? buf_data_q : instr_rdata_i;

  // Buffer occupancy after this edge
  always_comb begin
    if (buf_valid_q) begin
      // Entry leaves, a response this cycle takes its place
      buf_valid_d = id_ready_i ? instr_rvalid_i : 1'b1;
    end else begin
      buf_valid_d = instr_rvalid_i & ~id_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
    end else begin
      buf_valid_q <= buf_valid_d;
    end
  end

  // Response not taken by decode this cycle
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i && (buf_valid_q || !id_ready_i)) begin
      buf_data_q <= instr_rdata_i;
    end
  end

  //////////////////////////////
  // Requests
  //////////////////////////////

  // Only when the buffer can catch next cycle's response
  assign instr_req_o  = fetch_enable_i & ~buf_valid_d;
  assign instr_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= boot_addr_i;
    end else if (instr_req_o) begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,

  // From fetch
  input  logic      instr_valid_i,
  input  data_t     instr_i,
  output logic      id_ready_o,

  // Register file read ports
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  input  data_t     rs1_data_i,
  input  data_t     rs2_data_i,

  // Write-back from execute, for forwarding
  input  logic      wb_we_i,
  input  reg_addr_t wb_addr_i,
  input  data_t     wb_data_i,

  id_ex_if.decode   id_ex
);

  logic       valid_q;
  data_t      instr_q;

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_u;

  // Decode results
  alu_op_e    alu_op;
  data_t      imm;
  logic       use_imm;
  logic       rd_we;
  logic       is_store;

  // Source values after forwarding
  data_t      rs1_val;
  data_t      rs2_val;

  //////////////////////////////
  // Instruction register
  //////////////////////////////

  assign id_ready_o = ~valid_q | id_ex.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      instr_q <= NOP_INSTR;
    end else if (id_ready_o) begin
      valid_q <= instr_valid_i;
      if (instr_valid_i) begin
        instr_q <= instr_i;
      end
    end
  end

  //////////////////////////////
  // Decoder
  //////////////////////////////

  assign opcode = instr_q[6:0];
  assign funct3 = instr_q[14:12];
  assign funct7 = instr_q[31:25];

  // I, S and U immediates, sign extended
  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_u = {instr_q[31:12], 12'b0};

  always_comb begin
    // Defaults give a no-op
    alu_op   = ALU_ADD;
    imm      = imm_i;
    use_imm  = 1'b1;
    rd_we    = 1'b0;
    is_store = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op = ALU_PASS_B;
        imm    = imm_u;
        rd_we  = 1'b1;
      end
      OPC_OP_IMM: begin
        rd_we = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            alu_op = ALU_SLL;
            rd_we  = (funct7 == 7'b0000000);
          end
          3'b101: begin
            // SRAI carries funct7 bit 5
            alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            rd_we  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
          default: rd_we = 1'b0;
        endcase
      end
      OPC_OP: begin
        use_imm = 1'b0;
        if (funct7 == 7'b0000000) begin
          rd_we = 1'b1;
          case (funct3)
            3'b000: alu_op = ALU_ADD;
            3'b001: alu_op = ALU_SLL;
            3'b010: alu_op = ALU_SLT;
            3'b100: alu_op = ALU_XOR;
            3'b101: alu_op = ALU_SRL;
            3'b110: alu_op = ALU_OR;
            3'b111: alu_op = ALU_AND;
            default: rd_we = 1'b0;
          endcase
        end else if (funct7 == 7'b0100000) begin
          // SUB and SRA only
          alu_op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
          rd_we  = (funct3 == 3'b000) || (funct3 == 3'b101);
        end
      end
      OPC_STORE: begin
        // Word stores only, address is rs1 plus offset
        imm      = imm_s;
        is_store = (funct3 == 3'b010);
      end
      default: begin
        // Unknown opcode keeps the no-op defaults
      end
    endcase
  end

  //////////////////////////////
  // Operands and forwarding
  //////////////////////////////

  assign rs1_addr_o = instr_q[19:15];
  assign rs2_addr_o = instr_q[24:20];

  // Result leaving execute this cycle is not yet in the register file
  assign rs1_val = (wb_we_i && (wb_addr_i == rs1_addr_o) && (rs1_addr_o != '0))
                   ? wb_data_i : rs1_data_i;
  assign rs2_val = (wb_we_i && (wb_addr_i == rs2_addr_o) && (rs2_addr_o != '0))
                   ? wb_data_i : rs2_data_i;

  assign id_ex.valid      = valid_q;
  assign id_ex.alu_op     = alu_op;
  assign id_ex.operand_a  = rs1_val;
  assign id_ex.operand_b  = use_imm ? imm : rs2_val;
  assign id_ex.rd         = instr_q[11:7];
  assign id_ex.rd_we      = rd_we;
  assign id_ex.is_store   = is_store;
  assign id_ex.store_data = rs2_val;

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,

  id_ex_if.execute  id_ex,

  // Data bus, stores only
  output logic      data_req_o,
  output addr_t     data_addr_o,
  output data_t     data_wdata_o,
  input  logic      data_gnt_i,

  // Register write-back
  output logic      wb_we_o,
  output reg_addr_t wb_addr_o,
  output data_t     wb_data_o
);

  logic       valid_q;
  alu_op_e    alu_op_q;
  data_t      op_a_q;
  data_t      op_b_q;
  reg_addr_t  rd_q;
  logic       rd_we_q;
  logic       is_store_q;
  data_t      store_data_q;

  data_t      alu_result;
  logic [4:0] shamt;
  logic       store_wait;

  //////////////////////////////
  // Pipeline register
  //////////////////////////////

  // Ungranted store blocks the stage
  assign store_wait  = valid_q & is_store_q & ~data_gnt_i;
  assign id_ex.ready = ~store_wait;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (id_ex.ready) begin
      valid_q <= id_ex.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_ex.valid && id_ex.ready) begin
      alu_op_q     <= id_ex.alu_op;
      op_a_q       <= id_ex.operand_a;
      op_b_q       <= id_ex.operand_b;
      rd_q         <= id_ex.rd;
      rd_we_q      <= id_ex.rd_we;
      is_store_q   <= id_ex.is_store;
      store_data_q <= id_ex.store_data;
    end
  end

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign shamt = op_b_q[4:0];

  always_comb begin
    case (alu_op_q)
      ALU_ADD:    alu_result = op_a_q + op_b_q;
      ALU_SUB:    alu_result = op_a_q - op_b_q;
      ALU_SLL:    alu_result = op_a_q << shamt;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a_q) < $signed(op_b_q)};
      ALU_XOR:    alu_result = op_a_q ^ op_b_q;
      ALU_SRL:    alu_result = op_a_q >> shamt;
      ALU_SRA:    alu_result = $signed(op_a_q) >>> shamt;
      ALU_OR:     alu_result = op_a_q | op_b_q;
      ALU_AND:    alu_result = op_a_q & op_b_q;
      ALU_PASS_B: alu_result = op_b_q;
      default:    alu_result = '0;
    endcase
  end

  // Store address from the adder, payload steady while waiting
  assign data_req_o   = valid_q & is_store_q;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = store_data_q;

  // One cycle in execute, written on the closing edge
  assign wb_we_o   = valid_q & ~is_store_q & rd_we_q;
  assign wb_addr_o = rd_q;
  assign wb_data_o = alu_result;

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,

  // Read ports
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output data_t     rs1_data_o,
  output data_t     rs2_data_o,

  // Write port
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  data_t     wdata_i
);

  // x1 to x31, x0 has no storage
  data_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  fetch_enable_i,
  input  addr_t boot_addr_i,

  // Instruction bus
  output logic  instr_req_o,
  output addr_t instr_addr_o,
  input  logic  instr_rvalid_i,
  input  data_t instr_rdata_i,

  // Data bus
  output logic  data_req_o,
  output addr_t data_addr_o,
  output data_t data_wdata_o,
  input  logic  data_gnt_i
);

  // Fetch to decode
  logic      instr_valid;
  data_t     instr;
  logic      id_ready;

  // Register file reads
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     rs1_data;
  data_t     rs2_data;

  // Write-back, also forwarded to decode
  logic      wb_we;
  reg_addr_t wb_addr;
  data_t     wb_data;

  id_ex_if id_ex ();

  //////////////////////////////
  // Fetch
  //////////////////////////////

  if_stage if_stage_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr),
    .id_ready_i     (id_ready)
  );

  //////////////////////////////
  // Decode
  //////////////////////////////

  id_stage id_stage_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .id_ready_o    (id_ready),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .wb_we_i       (wb_we),
    .wb_addr_i     (wb_addr),
    .wb_data_i     (wb_data),
    .id_ex         (id_ex)
  );

  //////////////////////////////
  // Execute and write-back
  //////////////////////////////

  ex_stage ex_stage_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_ex        (id_ex),
    .data_req_o   (data_req_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .data_gnt_i   (data_gnt_i),
    .wb_we_o      (wb_we),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data)
  );

  register_file register_file_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we),
    .waddr_i    (wb_addr),
    .wdata_i    (wb_data)
  );

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        fetch_enable_i,
  input  logic [31:0] boot_addr_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  input  logic        data_gnt_i,
  input  int          exp_count_i,
  input  logic [31:0] exp_addr_i [0:63],
  input  logic [31:0] exp_data_i [0:63],
  output int          store_count_o,
  output int          value_errs_o,
  output int          proto_errs_o
);

  logic        seen_req;
  logic [31:0] next_addr;
  logic        pend_q;
  logic [31:0] pend_addr;
  logic [31:0] pend_data;

  initial begin
    store_count_o = 0;
    value_errs_o  = 0;
    proto_errs_o  = 0;
    seen_req      = 1'b0;
    next_addr     = '0;
    pend_q        = 1'b0;
    pend_addr     = '0;
    pend_data     = '0;
  end

  //////////////////////////////
  // Instruction requests
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i && instr_req_i) begin
      if (!fetch_enable_i) begin
        $display("Instruction request at %0t while fetch enable is low", $time);
        proto_errs_o++;
      end
      // First fetch from boot, then strictly sequential
      if (!seen_req) begin
        next_addr = boot_addr_i;
      end
      if (instr_addr_i != next_addr) begin
        $display("ERR t=%0t instr_addr_o expected %h got %h",
                 $time, next_addr, instr_addr_i);
        value_errs_o++;
      end
      seen_req  = 1'b1;
      next_addr = next_addr + 32'd4;
    end
  end

  //////////////////////////////
  // Data bus stores
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i) begin
      // Waiting store must stay put
      if (pend_q && (!data_req_i || data_addr_i != pend_addr || data_wdata_i != pend_data)) begin
        $display("Store at %0t changed or dropped before its grant", $time);
        proto_errs_o++;
      end
      if (data_req_i && data_gnt_i) begin
        if (store_count_o >= exp_count_i || store_count_o > 63) begin
          $display("Unexpected store number %0d beyond the expected list", store_count_o);
          proto_errs_o++;
        end else begin
          if (data_addr_i != exp_addr_i[store_count_o]) begin
            $display("ERR t=%0t data_addr_o expected %h got %h",
                     $time, exp_addr_i[store_count_o], data_addr_i);
            value_errs_o++;
          end
          if (data_wdata_i != exp_data_i[store_count_o]) begin
            $display("ERR t=%0t data_wdata_o expected %h got %h",
                     $time, exp_data_i[store_count_o], data_wdata_i);
            value_errs_o++;
          end
        end
        store_count_o++;
      end
      pend_q    = data_req_i & ~data_gnt_i;
      pend_addr = data_addr_i;
      pend_data = data_wdata_i;
    end
  end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
  localparam logic [31:0] NOP_WORD  = 32'h0000_0013;
  localparam int          STORE_TIMEOUT = 3000;

  logic        clk_i;
  logic        reset_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;

  // Raw pattern file image
  logic [31:0] pat [0:255];
  logic [31:0] exp_addr [0:63];
  logic [31:0] exp_data [0:63];
  int          n_words;
  int          n_stores;
  int          store_count;
  int          value_errs;
  int          proto_errs;
  int          timeout_errs;
  int          cycles;
  logic [31:0] lfsr_q;
  logic        req_seen;
  logic [31:0] req_addr;

  core_top dut_i (.*);

  tb_checker checker_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .data_req_i     (data_req_o),
    .data_addr_i    (data_addr_o),
    .data_wdata_i   (data_wdata_o),
    .data_gnt_i     (data_gnt_i),
    .exp_count_i    (n_stores),
    .exp_addr_i     (exp_addr),
    .exp_data_i     (exp_data),
    .store_count_o  (store_count),
    .value_errs_o   (value_errs),
    .proto_errs_o   (proto_errs)
  );

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // NOP outside the loaded program
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (addr < BOOT_ADDR || idx >= 32'(n_words)) begin
      return NOP_WORD;
    end
    return pat[idx + 32'd2];
  endfunction

  //////////////////////////////
  // Memory model and grants
  //////////////////////////////

  always @(posedge clk_i) begin
    req_seen = instr_req_o;
    req_addr = instr_addr_o;
    #1;
    instr_rvalid_i = req_seen;
    instr_rdata_i  = req_seen ? fetch_word(req_addr) : '0;
    // One LFSR bit per cycle
    lfsr_q     = lfsr_next(lfsr_q);
    data_gnt_i = lfsr_q[0];
  end

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    lfsr_q         = 32'h9e9b_3d69;
    timeout_errs   = 0;
    n_words        = 0;
    n_stores       = 0;
    for (int i = 0; i < 256; i++) begin
      pat[i] = '0;
    end
    $readmemh("testbench/program_patterns.txt", pat);
    n_words  = int'(pat[0]);
    n_stores = int'(pat[1]);
    for (int k = 0; k < 64; k++) begin
      exp_addr[k] = (k < n_stores) ? pat[2 + n_words + 2 * k] : '0;
      exp_data[k] = (k < n_stores) ? pat[3 + n_words + 2 * k] : '0;
    end

    // Reset for 8 cycles
    cycles = 0;
    while (cycles < 8) begin
      @(posedge clk_i);
      cycles++;
    end
    #1 reset_i = 1'b0;

    // Core stays idle with fetch disabled
    cycles = 0;
    while (cycles < 10) begin
      @(posedge clk_i);
      cycles++;
    end
    #1 fetch_enable_i = 1'b1;

    cycles = 0;
    while (store_count < n_stores && cycles < STORE_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (store_count < n_stores) begin
      $display("Timeout: only %0d of %0d stores seen", store_count, n_stores);
      timeout_errs++;
    end

    // Catch stray stores
    cycles = 0;
    while (cycles < 40) begin
      @(posedge clk_i);
      cycles++;
    end
    #1;
    $display("Stores %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             store_count, value_errs, proto_errs, timeout_errs);
    if (value_errs == 0 && proto_errs == 0 && timeout_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
design/core_pkg.sv
design/id_ex_if.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/register_file.sv
design/core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_top -o tb_top_sim

./obj_dir/tb_top_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- testbench/program_patterns.txt
// Header: program word count, expected store count (hex)
// Then program words from 0x100, then store address/data pairs in order
002B 0015
123450B7 40102023 FFB00113 40202223 00112193 40302423
0FF0C213 5A006293 7F027313 00411393 01C15413 40115493
40402623 40502823 40602A23 40702C23 40802E23 42902023
00508533 405185B3 00329633 003126B3 0020C733 003157B3
40315833 0050E8B3 0020F933
42A02223 42B02423 42C02623 42D02823 42E02A23 42F02C23
43002E23 45102023 45202223
// Dependent chain and x0 write
00700993 00398993 45302423 00500013 44002623 60000A13 013A2223
// Expected stores
00000400 12345000
00000404 FFFFFFFB
00000408 00000001
0000040C 123450FF
00000410 000005A0
00000414 000000F0
00000418 FFFFFFB0
0000041C 0000000F
00000420 FFFFFFFD
00000424 123455A0
00000428 FFFFFA61
0000042C 00000B40
00000430 00000001
00000434 EDCBAFFB
00000438 7FFFFFFD
0000043C FFFFFFFD
00000440 123455A0
00000444 12345000
00000448 0000000A
0000044C 00000000
00000604 0000000A
